// ==== list.f ====
+incdir+verif
src/chacha_pkg.sv
src/chacha_lane_if.sv
src/chacha_round.sv
src/chacha_block_core.sv
src/keystream_merger.sv
src/chacha_top.sv
verif/chacha_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module chacha_tb -f list.f -Mdir obj_dir -o chacha_sim
./obj_dir/chacha_sim > sim.log 2>&1 || true
cat sim.log
grep -q "SIMULATION PASSED" sim.log

// ==== verif/chacha_model.svh ====
`ifndef CHACHA_MODEL_SVH
`define CHACHA_MODEL_SVH

// Reference ChaCha block function, rounds written out group by group

function automatic chacha_pkg::state_t mix_group(chacha_pkg::state_t s,
                                                 int a, int b, int c, int d);
    chacha_pkg::quad_t q;
    q    = chacha_pkg::quarter_round(s[a], s[b], s[c], s[d]);
    s[a] = q[0];
    s[b] = q[1];
    s[c] = q[2];
    s[d] = q[3];
    return s;
endfunction

function automatic chacha_pkg::state_t chacha_block_model(chacha_pkg::key_t k,
        chacha_pkg::nonce_t n, chacha_pkg::counter_t ctr, int double_rounds);
    chacha_pkg::state_t start_state;
    chacha_pkg::state_t x;
    // "expand 32-byte k"
    start_state[0] = 32'h6170_7865;
    start_state[1] = 32'h3320_646e;
    start_state[2] = 32'h7962_2d32;
    start_state[3] = 32'h6b20_6574;
    for (int i = 0; i < 8; i++) begin
        start_state[4 + i] = k[32 * i +: 32];
    end
    start_state[12] = ctr;
    for (int i = 0; i < 3; i++) begin
        start_state[13 + i] = n[32 * i +: 32];
    end
    x = start_state;
    for (int r = 0; r < double_rounds; r++) begin
        x = mix_group(x, 0, 4, 8, 12);
        x = mix_group(x, 1, 5, 9, 13);
        x = mix_group(x, 2, 6, 10, 14);
        x = mix_group(x, 3, 7, 11, 15);
        // Diagonals
        x = mix_group(x, 0, 5, 10, 15);
        x = mix_group(x, 1, 6, 11, 12);
        x = mix_group(x, 2, 7, 8, 13);
        x = mix_group(x, 3, 4, 9, 14);
    end
    for (int i = 0; i < 16; i++) begin
        x[i] = x[i] + start_state[i];
    end
    return x;
endfunction

`endif

// ==== verif/chacha_tb.sv ====
`timescale 1ns/1ps

module chacha_tb;

    localparam int CLK_PERIOD    = 10;
    localparam int DOUBLE_ROUNDS = 10;
    localparam int CREDITS       = 4;
    localparam int NUM_TESTS     = 6;

    logic                  clk       = 1'b0;
    logic                  rst_n;
    logic                  start;
    logic                  ready;
    chacha_pkg::key_t      key;
    chacha_pkg::nonce_t    nonce;
    chacha_pkg::counter_t  counter;
    logic                  ks_valid;
    chacha_pkg::word_t     ks_word;
    logic                  ks_credit = 1'b0;

    // Stimulus table
    string                 test_name    [NUM_TESTS];
    chacha_pkg::key_t      test_key     [NUM_TESTS];
    chacha_pkg::nonce_t    test_nonce   [NUM_TESTS];
    chacha_pkg::counter_t  test_counter [NUM_TESTS];
    int                    test_hold    [NUM_TESTS];

    // Expected stream appended per request
    chacha_pkg::word_t     exp_words [$];
    string                 exp_names [$];
    int                    rd_pos     = 0;
    int                    cycle      = 0;
    int                    hold_until = 0;
    int                    owed       = 0;
    int                    spent      = 0;
    int                    returned   = 0;
    int                    gap        = 0;

    `include "chacha_model.svh"

    chacha_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .ready     (ready),
        .key       (key),
        .nonce     (nonce),
        .counter   (counter),
        .ks_valid  (ks_valid),
        .ks_word   (ks_word),
        .ks_credit (ks_credit)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================================================
    // Failure reporting and checks
    // ========================================================================

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic report_failure(string what);
        $display("%s", what);
        abort_run();
    endtask

    task automatic compare_word(string name, chacha_pkg::word_t exp, chacha_pkg::word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %08h, actual %08h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_counter(string name, chacha_pkg::counter_t exp,
                                 chacha_pkg::counter_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %08h, actual %08h", name, exp, act);
            abort_run();
        end
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================

    task automatic fill_table();
        for (int i = 0; i < NUM_TESTS; i++) begin
            for (int w = 0; w < 8; w++) begin
                test_key[i][32 * w +: 32] = $urandom;
            end
            test_nonce[i]   = {$urandom, $urandom, $urandom};
            test_counter[i] = $urandom;
            test_hold[i]    = 0;
        end
        test_name[0]    = "rfc8439_block";
        test_key[0]     = {32'h1f1e_1d1c, 32'h1b1a_1918, 32'h1716_1514, 32'h1312_1110,
                           32'h0f0e_0d0c, 32'h0b0a_0908, 32'h0706_0504, 32'h0302_0100};
        test_nonce[0]   = {32'h0000_0000, 32'h4a00_0000, 32'h0900_0000};
        test_counter[0] = 32'd1;
        test_name[1]    = "random_a";
        test_name[2]    = "counter_wrap";
        test_counter[2] = 32'hffff_ffff;
        test_name[3]    = "credit_hold";
        test_hold[3]    = 80;
        test_name[4]    = "random_b";
        test_name[5]    = "overlap_hold";
        test_hold[5]    = 120;
    endtask

    task automatic apply_entry(int i);
        chacha_pkg::state_t    blk      [2];
        chacha_pkg::counter_t  lane_ctr [2];
        int                    n;
        lane_ctr[0] = test_counter[i];
        lane_ctr[1] = test_counter[i] + 32'd1;
        for (int l = 0; l < 2; l++) begin
            blk[l] = chacha_block_model(test_key[i], test_nonce[i], lane_ctr[l], DOUBLE_ROUNDS);
            for (int w = 0; w < 16; w++) begin
                exp_words.push_back(blk[l][w]);
                exp_names.push_back($sformatf("%s lane %0d word %0d", test_name[i], l, w));
            end
        end
        // First word of the RFC 8439 section 2.3.2 block
        if (i == 0) begin
            exp_words[exp_words.size() - 32] = 32'he4e7_f110;
        end
        start   = 1'b1;
        key     = test_key[i];
        nonce   = test_nonce[i];
        counter = test_counter[i];
        @(posedge clk);
        #1;
        start      = 1'b0;
        hold_until = cycle + test_hold[i];
        check_counter({test_name[i], " lane 0 counter"}, lane_ctr[0],
                      dut0.g_lane[0].u_core.init_state[12]);
        check_counter({test_name[i], " lane 1 counter"}, lane_ctr[1],
                      dut0.g_lane[1].u_core.init_state[12]);
        // Ready stays low until the merger has both blocks
        n = 0;
        while (!ready) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n < 2 * DOUBLE_ROUNDS + 1) begin
            report_failure($sformatf("%s: ready rose %0d cycles after accept, too early",
                                     test_name[i], n));
        end
        // Lanes are released only into an empty merger
        if (rd_pos != exp_words.size() - 32) begin
            report_failure($sformatf("%s: ready did not rise with the release of the lanes",
                                     test_name[i]));
        end
    endtask

    // Word checker and credit return
    always @(posedge clk) begin
        cycle++;
        if (ks_valid) begin
            if (rd_pos >= exp_words.size()) begin
                report_failure("ks_valid was high while no word was expected");
            end else begin
                compare_word(exp_names[rd_pos], exp_words[rd_pos], ks_word);
                rd_pos++;
                owed++;
                spent++;
            end
        end
        if (ks_credit) begin
            returned++;
        end
        if (spent - returned > CREDITS) begin
            report_failure("More words were sent than the credits allow");
        end
        #1;
        ks_credit = 1'b0;
        if (owed > 0 && cycle >= hold_until) begin
            if (gap == 0) begin
                ks_credit = 1'b1;
                owed--;
                gap = $urandom % 6;
            end else begin
                gap--;
            end
        end
    end

    initial begin
        void'($urandom(32'hb093_8b86));
        rst_n   = 1'b0;
        start   = 1'b0;
        key     = '0;
        nonce   = '0;
        counter = '0;
        fill_table();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Idle period with no request
        repeat (50) begin
            @(posedge clk);
            #1;
            if (!ready || ks_valid) begin
                report_failure("DUT was not idle after reset");
            end
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            apply_entry(i);
        end
        while (rd_pos < exp_words.size()) begin
            @(posedge clk);
            #1;
        end
        repeat (20) @(posedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #((NUM_TESTS * 200 + 1000) * CLK_PERIOD);
        report_failure("Timeout: the keystream did not complete in time");
    end

endmodule

// ==== src/chacha_top.sv ====
`timescale 1ns/1ps

// ChaCha20 keystream generator, two block lanes and one word stream
module chacha_top #(
    parameter int DOUBLE_ROUNDS = 10,
    parameter int CREDITS       = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    output logic                  ready,
    input  chacha_pkg::key_t      key,
    input  chacha_pkg::nonce_t    nonce,
    input  chacha_pkg::counter_t  counter,
    output logic                  ks_valid,
    output chacha_pkg::word_t     ks_word,
    input  logic                  ks_credit
);

    logic accept;
    logic busy;

    chacha_lane_if lane_if [chacha_pkg::NUM_LANES] ();

    // ========================================================================
    // Input handshake
    // ========================================================================

    assign accept = start & ready;
    assign ready  = ~busy;

    // Tracks the lane FSMs, which leave idle on accept and return on taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (lane_if[0].taken) begin
            busy <= 1'b0;
        end
    end

    // ========================================================================
    // Lanes
    // ========================================================================

    for (genvar g = 0; g < chacha_pkg::NUM_LANES; g++) begin : g_lane
        assign lane_if[g].start         = accept;
        assign lane_if[g].key           = key;
        assign lane_if[g].nonce         = nonce;
        // Lane g computes block counter + g, wrapping at 2^32
        assign lane_if[g].block_counter = counter + chacha_pkg::counter_t'(g);

        chacha_block_core #(
            .DOUBLE_ROUNDS (DOUBLE_ROUNDS)
        ) u_core (
            .clk   (clk),
            .rst_n (rst_n),
            .lane  (lane_if[g])
        );
    end

    keystream_merger #(
        .CREDITS (CREDITS)
    ) u_merger (
        .clk       (clk),
        .rst_n     (rst_n),
        .lane0     (lane_if[0]),
        .lane1     (lane_if[1]),
        .ks_credit (ks_credit),
        .ks_valid  (ks_valid),
        .ks_word   (ks_word)
    );

endmodule

// ==== src/keystream_merger.sv ====
`timescale 1ns/1ps

// Collects both lane blocks and sends them out word by word
module keystream_merger #(
    parameter int CREDITS = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    chacha_lane_if.drain        lane0,
    chacha_lane_if.drain        lane1,
    input  logic                ks_credit,
    output logic                ks_valid,
    output chacha_pkg::word_t   ks_word
);

    localparam int NUM_WORDS = 32;
    localparam int IDX_W     = $clog2(NUM_WORDS);
    localparam int CREDIT_W  = $clog2(CREDITS + 1);
    localparam logic [IDX_W-1:0] LAST_WORD = IDX_W'(NUM_WORDS - 1);

    chacha_pkg::word_t      word_buf [0:NUM_WORDS-1];
    logic                   buf_loaded;
    logic [IDX_W-1:0]       rd_idx;
    logic [CREDIT_W-1:0]    credits;

    logic                   capture;
    logic                   send;

    // ========================================================================
    // Capture
    // ========================================================================

    // Both lanes finish in the same cycle, so they are taken together
    assign capture     = lane0.done & lane1.done & ~buf_loaded;
    assign lane0.taken = capture;
    assign lane1.taken = capture;

    // Lane 0 fills words 0 to 15, lane 1 words 16 to 31
    always_ff @(posedge clk) begin
        if (capture) begin
            for (int i = 0; i < 16; i++) begin
                word_buf[i]      <= lane0.block[i];
                word_buf[16 + i] <= lane1.block[i];
            end
        end
    end

    // ========================================================================
    // Word output
    // ========================================================================

    assign send     = buf_loaded & (credits != '0);
    assign ks_valid = send;
    assign ks_word  = word_buf[rd_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_loaded <= 1'b0;
            rd_idx     <= '0;
        end else if (capture) begin
            buf_loaded <= 1'b1;
        end else if (send) begin
            // Index wraps back to 0 after the last word
            rd_idx <= rd_idx + 1'b1;
            if (rd_idx == LAST_WORD) begin
                buf_loaded <= 1'b0;
            end
        end
    end

    // Spend and return may happen in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CREDIT_W'(CREDITS);
        end else begin
            case ({send, ks_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// ==== src/chacha_block_core.sv ====
`timescale 1ns/1ps

// One ChaCha block lane
module chacha_block_core #(
    parameter int DOUBLE_ROUNDS = 10
) (
    input logic          clk,
    input logic          rst_n,
    chacha_lane_if.core  lane
);

    localparam int NUM_ROUNDS = 2 * DOUBLE_ROUNDS;
    localparam int CNT_W      = $clog2(NUM_ROUNDS);
    localparam logic [CNT_W-1:0] LAST_ROUND = CNT_W'(NUM_ROUNDS - 1);

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_ROUNDS,
        LANE_FEED,
        LANE_DONE
    } lane_state_e;

    lane_state_e         state;
    logic [CNT_W-1:0]    round_cnt;

    chacha_pkg::state_t  setup_state;
    chacha_pkg::state_t  init_state;
    chacha_pkg::state_t  work_state;
    chacha_pkg::state_t  round_out;
    chacha_pkg::state_t  result;

    // ========================================================================
    // Initial state
    // ========================================================================

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            setup_state[i] = chacha_pkg::SIGMA[i];
        end
        for (int i = 0; i < 8; i++) begin
            setup_state[4 + i] = lane.key[32 * i +: 32];
        end
        setup_state[12] = lane.block_counter;
        for (int i = 0; i < 3; i++) begin
            setup_state[13 + i] = lane.nonce[32 * i +: 32];
        end
    end

    // Even rounds work on columns, odd rounds on diagonals
    chacha_round u_round (
        .state_in  (work_state),
        .diagonal  (round_cnt[0]),
        .state_out (round_out)
    );

    // ========================================================================
    // Sequencing
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= LANE_IDLE;
            round_cnt <= '0;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (lane.start) begin
                        state     <= LANE_ROUNDS;
                        round_cnt <= '0;
                    end
                end
                LANE_ROUNDS: begin
                    if (round_cnt == LAST_ROUND) begin
                        state <= LANE_FEED;
                    end else begin
                        round_cnt <= round_cnt + 1'b1;
                    end
                end
                LANE_FEED: state <= LANE_DONE;
                LANE_DONE: begin
                    // Released once the merger has the block
                    if (lane.taken) begin
                        state <= LANE_IDLE;
                    end
                end
                default: state <= LANE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            LANE_IDLE: begin
                if (lane.start) begin
                    init_state <= setup_state;
                    work_state <= setup_state;
                end
            end
            LANE_ROUNDS: work_state <= round_out;
            LANE_FEED: begin
                // Feed-forward of the initial state
                for (int i = 0; i < 16; i++) begin
                    result[i] <= work_state[i] + init_state[i];
                end
            end
            default: ;
        endcase
    end

    assign lane.done  = (state == LANE_DONE);
    assign lane.block = result;

endmodule

// ==== src/chacha_round.sv ====
`timescale 1ns/1ps

// One column or diagonal round, fully combinational
module chacha_round (
    input  chacha_pkg::state_t state_in,
    input  logic               diagonal,
    output chacha_pkg::state_t state_out
);

    always_comb begin
        logic [3:0]         idx [0:3];
        chacha_pkg::quad_t  q;

        // Every word is touched by exactly one quarter round
        state_out = state_in;

        for (int g = 0; g < 4; g++) begin
            for (int k = 0; k < 4; k++) begin
                if (diagonal) begin
                    idx[k] = chacha_pkg::DIAG_IDX[g][k];
                end else begin
                    idx[k] = chacha_pkg::COL_IDX[g][k];
                end
            end

            // The four groups are disjoint, so all read the input state
            q = chacha_pkg::quarter_round(state_in[idx[0]],
                                          state_in[idx[1]],
                                          state_in[idx[2]],
                                          state_in[idx[3]]);

            for (int k = 0; k < 4; k++) begin
                state_out[idx[k]] = q[k];
            end
        end
    end

endmodule

// ==== src/chacha_lane_if.sv ====
`timescale 1ns/1ps

// Link between one block lane and the keystream merger
interface chacha_lane_if;

    // Job, driven by the top level
    logic                  start;
    chacha_pkg::key_t      key;
    chacha_pkg::nonce_t    nonce;
    chacha_pkg::counter_t  block_counter;

    // Result, held by the lane until the merger takes it
    logic                  done;
    chacha_pkg::state_t    block;
    logic                  taken;

    modport core (
        input  start,
        input  key,
        input  nonce,
        input  block_counter,
        input  taken,
        output done,
        output block
    );

    modport drain (
        input  done,
        input  block,
        output taken
    );

endinterface

// ==== src/chacha_pkg.sv ====
package chacha_pkg;

    // ========================================================================
    // Types
    // ========================================================================

    typedef logic [31:0]  word_t;
    typedef logic [255:0] key_t;
    typedef logic [95:0]  nonce_t;
    typedef logic [31:0]  counter_t;

    // Word 0 sits in the lowest 32 bits
    typedef word_t [15:0] state_t;

    // Result of one quarter round, element 0 is a
    typedef word_t [3:0]  quad_t;

    localparam int NUM_LANES = 2;

    // "expand 32-byte k"
    localparam word_t SIGMA [0:3] = '{32'h6170_7865, 32'h3320_646e,
                                      32'h7962_2d32, 32'h6b20_6574};

    // Word indices a, b, c, d of each quarter round
    localparam logic [3:0] COL_IDX [0:3][0:3] = '{'{4'd0, 4'd4, 4'd8,  4'd12},
                                                  '{4'd1, 4'd5, 4'd9,  4'd13},
                                                  '{4'd2, 4'd6, 4'd10, 4'd14},
                                                  '{4'd3, 4'd7, 4'd11, 4'd15}};

    localparam logic [3:0] DIAG_IDX [0:3][0:3] = '{'{4'd0, 4'd5, 4'd10, 4'd15},
                                                   '{4'd1, 4'd6, 4'd11, 4'd12},
                                                   '{4'd2, 4'd7, 4'd8,  4'd13},
                                                   '{4'd3, 4'd4, 4'd9,  4'd14}};

    // ========================================================================
    // Quarter round
    // ========================================================================

    function automatic word_t rotl(word_t x, int unsigned n);
        return (x << n) | (x >> (32 - n));
    endfunction

    function automatic quad_t quarter_round(word_t a, word_t b, word_t c, word_t d);
        quad_t q;
        a = a + b;
        d = rotl(d ^ a, 16);
        c = c + d;
        b = rotl(b ^ c, 12);
        a = a + b;
        d = rotl(d ^ a, 8);
        c = c + d;
        b = rotl(b ^ c, 7);
        q[0] = a;
        q[1] = b;
        q[2] = c;
        q[3] = d;
        return q;
    endfunction

endpackage
